//--- bench/alu_subsystem_sva.sv
// Concurrent assertions on core strobes, trigger pulse and FIFO flags,
// bound into the subsystem top to see the core and FIFO together
`timescale 1ns/1ps

module alu_subsystem_sva (
    input logic                clk,
    input logic                rst,
    input logic                alu_enable,
    input alu_pkg::alu_state_t core_state,
    input logic                core_done,
    input logic                force_clear,
    input logic                result_strobe,
    input logic                fifo_empty,
    input logic                fifo_full
);

    logic op_start;  // Enabled IDLE with no result held

    assign op_start = (core_state == alu_pkg::IDLE) && alu_enable && !core_done && !force_clear;

    strobe_single: assert property (@(posedge clk) disable iff (rst)
        result_strobe |=> !result_strobe)
        else $error("result_strobe lasted more than one cycle");

    // A clear in EXECUTE or RESULT cancels the strobe
    strobe_latency: assert property (@(posedge clk) disable iff (rst)
        op_start |-> ##3 (result_strobe || $past(force_clear) || $past(force_clear, 2)))
        else $error("result_strobe missing three cycles after operation start");

    flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(fifo_empty && fifo_full))
        else $error("FIFO empty and full at the same time");

    clear_single: assert property (@(posedge clk) disable iff (rst)
        force_clear |=> !force_clear)
        else $error("force_clear lasted two cycles");

endmodule

bind alu_subsystem alu_subsystem_sva i_sva (
    .clk           (clk),
    .rst           (rst),
    .alu_enable    (alu_enable),
    .core_state    (i_core.state),
    .core_done     (i_core.done),
    .force_clear   (force_clear),
    .result_strobe (result_strobe),
    .fifo_empty    (fifo_empty),
    .fifo_full     (fifo_full)
);

//--- bench/tb_alu_subsystem.sv
// Testbench for the ALU subsystem: directed and random operations,
// FIFO fill and overflow, empty pop and the tap trigger clear
`timescale 1ns/1ps
`include "alu_consts.svh"

module tb_alu_subsystem;

    logic                clk;
    logic                rst;
    alu_pkg::alu_word_t  operand_a;
    alu_pkg::alu_word_t  operand_b;
    alu_pkg::alu_op_t    alu_op;
    logic                alu_enable;
    logic                result_pop;
    alu_pkg::alu_word_t  head_result;
    alu_pkg::alu_flags_t head_flags;
    logic                fifo_empty;
    logic                fifo_full;
    logic                fifo_overflow;

    // Tap stream model
    trig_pkg::lfsr_t    m_lfsr;
    trig_pkg::tap_sel_t m_sel;
    logic               m_armed;  // First trigger byte seen

    logic [31:0] rng;
    int          n_errors;
    int          n_checked;
    int          n_skipped;
    bit          timed_out;

    alu_subsystem i_dut (
        .clk           (clk),
        .rst           (rst),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .alu_op        (alu_op),
        .alu_enable    (alu_enable),
        .result_pop    (result_pop),
        .head_result   (head_result),
        .head_flags    (head_flags),
        .fifo_empty    (fifo_empty),
        .fifo_full     (fifo_full),
        .fifo_overflow (fifo_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v   = {v[30:0], rng[0]};
            rng = rng[0] ? ((rng >> 1) ^ 32'h8020_0003) : (rng >> 1);  // Galois step
        end
        return v;
    endfunction

    function automatic trig_pkg::lfsr_t lfsr_next(input trig_pkg::lfsr_t l);
        return {l[18:0], l[19] ^ l[16] ^ l[13] ^ l[1]};
    endfunction

    function automatic trig_pkg::tap_byte_t tap_of(input trig_pkg::lfsr_t l,
            input trig_pkg::tap_sel_t s, input alu_pkg::alu_word_t a, b);
        case (s)
            2'd0:    return l[7:0];
            2'd1:    return l[15:8];
            2'd2:    return l[19:12] ^ a[7:0];
            default: return l[7:0] ^ b[7:0];
        endcase
    endfunction

    // True if the three tap bytes of one operation complete the pattern
    function automatic bit op_fires(input alu_pkg::alu_word_t a, b);
        trig_pkg::lfsr_t     l;
        trig_pkg::tap_sel_t  s;
        trig_pkg::tap_byte_t t;
        logic                armed;
        int                  i;
        l = m_lfsr;
        s = m_sel;
        armed = m_armed;
        for (i = 0; i < 3; i++) begin
            t = tap_of(l, s, a, b);
            if (armed && t == `TRIG_BYTE1)
                return 1'b1;
            armed = (t == `TRIG_BYTE0);
            l = lfsr_next(l);
            s = s + 2'd1;
        end
        return 1'b0;
    endfunction

    // Expected {flags, result}
    function automatic logic [19:0] ref_alu(input alu_pkg::alu_op_t op,
            input alu_pkg::alu_word_t a, b);
        logic [16:0]        s;
        logic [31:0]        p;
        alu_pkg::alu_word_t r;
        logic               c;
        logic               v;
        c = 1'b0;
        v = 1'b0;
        case (op)
            `OP_ADD: begin
                s = a + b;
                r = s[15:0];
                c = s[16];
                v = (a[15] == b[15]) && (r[15] != a[15]);
            end
            `OP_SUB: begin
                r = a - b;
                c = (a < b);  // Borrow
                v = (a[15] != b[15]) && (r[15] != a[15]);
            end
            `OP_AND: r = a & b;
            `OP_OR:  r = a | b;
            `OP_XOR: r = a ^ b;
            `OP_NOT: r = ~a;
            `OP_SHL: begin
                r = a << 1;
                c = a[15];
                v = a[15] ^ a[14];
            end
            `OP_SHR: r = a >> 1;
            // Sign bits decide unless they match
            `OP_SLT: r = (a[15] != b[15]) ? {15'd0, a[15]} : ((a < b) ? 16'd1 : 16'd0);
            `OP_EQ:  r = (a == b) ? 16'd1 : 16'd0;
            `OP_MUL: begin
                p = a * b;
                r = p[15:0];
                c = |p[31:16];
                v = c;
            end
            `OP_DIV: r = (b == 16'd0) ? 16'hFFFF : a / b;
            default: r = '0;
        endcase
        return {r == 16'd0, c, v, r[15], r};
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        n_errors++;
    endtask

    // One clock step; checks and advances the tap model on enabled cycles
    task automatic tick();
        trig_pkg::tap_byte_t t;
        #1;
        if (alu_enable) begin
            t = tap_of(m_lfsr, m_sel, operand_a, operand_b);
            if (i_dut.tap_byte !== t)
                report_mismatch($sformatf("tap byte %h, expected %h", i_dut.tap_byte, t));
            m_armed = (t == `TRIG_BYTE0);
            m_lfsr  = lfsr_next(m_lfsr);
            m_sel   = m_sel + 2'd1;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic run_op(input alu_pkg::alu_op_t op, input alu_pkg::alu_word_t a, b,
            output bit ran);
        int n;
        ran = 1'b0;
        if (op_fires(a, b)) begin
            $display("Skipped op %0d: tap stream would hit the trigger", op);
            n_skipped++;
        end else begin
            operand_a  = a;
            operand_b  = b;
            alu_op     = op;
            alu_enable = 1'b1;
            n = 0;
            while (i_dut.result_strobe !== 1'b1 && n < 20) begin
                tick();
                n++;
            end
            if (i_dut.result_strobe !== 1'b1) begin
                $display("Timeout: no result strobe within 20 cycles at %0t ns", $time);
                n_errors++;
                timed_out = 1'b1;
            end
            alu_enable = 1'b0;
            tick();  // Push lands in the FIFO
            ran = 1'b1;
        end
    endtask

    task automatic pop_check(input alu_pkg::alu_word_t exp_r, input alu_pkg::alu_flags_t exp_f);
        n_checked++;
        if (fifo_empty !== 1'b0) begin
            report_mismatch("FIFO empty where a result was expected");
        end else begin
            if (head_result !== exp_r || head_flags !== exp_f)
                report_mismatch($sformatf("head %h flags %b, expected %h flags %b",
                    head_result, head_flags, exp_r, exp_f));
            result_pop = 1'b1;
            tick();
            result_pop = 1'b0;
        end
    endtask

    task automatic check_op(input alu_pkg::alu_op_t op, input alu_pkg::alu_word_t a, b);
        logic [19:0] e;
        bit          ran;
        e = ref_alu(op, a, b);
        run_op(op, a, b, ran);
        if (ran)
            pop_check(e[15:0], e[19:16]);
    endtask

    task automatic directed_ops();
        check_op(`OP_ADD, 16'hFFFF, 16'h0001);  // Carry out, zero
        check_op(`OP_ADD, 16'h7FFF, 16'h0001);  // Signed overflow
        check_op(`OP_SUB, 16'h0001, 16'h0002);  // Borrow
        check_op(`OP_SUB, 16'h8000, 16'h0001);
        check_op(`OP_AND, 16'hF0F0, 16'h3C3C);
        check_op(`OP_OR,  16'hF000, 16'h000F);
        check_op(`OP_XOR, 16'hAAAA, 16'hAAAA);
        check_op(`OP_NOT, 16'h00FF, 16'h0000);
        check_op(`OP_SHL, 16'h4001, 16'h0000);  // MSB changes
        check_op(`OP_SHL, 16'h8000, 16'h0000);
        check_op(`OP_SHR, 16'h8001, 16'h0000);
        check_op(`OP_SLT, 16'hFFFE, 16'h0001);  // -2 < 1
        check_op(`OP_SLT, 16'h0001, 16'hFFFF);
        check_op(`OP_SLT, 16'h8000, 16'hFFFF);
        check_op(`OP_EQ,  16'h1234, 16'h1234);
        check_op(`OP_MUL, 16'h1234, 16'h5678);  // High half nonzero
        check_op(`OP_MUL, 16'h0003, 16'h0004);
        check_op(`OP_DIV, 16'h1234, 16'h0000);  // Divide by zero
        check_op(`OP_DIV, 16'd100,  16'd7);
    endtask

    task automatic random_ops();
        int i;
        for (i = 0; i < 24; i++)
            check_op(4'(i % 12), 16'(rand_bits(16)), 16'(rand_bits(16)));
    endtask

    task automatic run_trigger();
        alu_pkg::alu_word_t a;
        alu_pkg::alu_word_t b;
        trig_pkg::lfsr_t    l_next;
        int                 n;
        n = 0;
        // Line up select 2 on the first enabled edge
        while (m_sel != 2'd2 && n < 16) begin
            check_op(`OP_ADD, 16'(rand_bits(16)), 16'(rand_bits(16)));
            n++;
        end
        if (m_sel != 2'd2) begin
            $display("Could not align the tap select for the trigger test");
            n_errors++;
            return;
        end
        l_next = lfsr_next(m_lfsr);
        a = {8'(rand_bits(8)), m_lfsr[19:12] ^ `TRIG_BYTE0};
        b = {8'(rand_bits(8)), l_next[7:0] ^ `TRIG_BYTE1};
        operand_a  = a;
        operand_b  = b;
        alu_op     = `OP_ADD;
        alu_enable = 1'b1;
        tick();
        tick();
        if (i_dut.force_clear !== 1'b1)
            report_mismatch("force_clear not raised by the trigger pattern");
        tick();
        if (i_dut.result_strobe !== 1'b0)
            report_mismatch("result strobe not suppressed by force_clear");
        alu_enable = 1'b0;
        for (n = 0; n < 4; n++) begin
            tick();
            if (fifo_empty !== 1'b1)
                report_mismatch("cleared operation left a FIFO entry");
        end
        check_op(`OP_XOR, 16'(rand_bits(16)), 16'(rand_bits(16)));
    endtask

    task automatic fill_fifo();
        alu_pkg::alu_word_t  exp_r [$];
        alu_pkg::alu_flags_t exp_f [$];
        alu_pkg::alu_word_t  a;
        alu_pkg::alu_word_t  b;
        logic [19:0]         e;
        bit                  ran;
        int                  n;
        n = 0;
        while (exp_r.size() < 5 && n < 20) begin
            a = 16'(rand_bits(16));
            b = 16'(rand_bits(16));
            e = ref_alu(4'(n % 12), a, b);
            run_op(4'(n % 12), a, b, ran);
            if (ran) begin
                exp_r.push_back(e[15:0]);
                exp_f.push_back(e[19:16]);
                if (exp_r.size() == 4 && (fifo_full !== 1'b1 || fifo_overflow !== 1'b0))
                    report_mismatch($sformatf("after 4 pushes full %b overflow %b",
                        fifo_full, fifo_overflow));
                if (exp_r.size() == 5 && fifo_overflow !== 1'b1)
                    report_mismatch("fifth push did not set overflow");
            end
            n++;
        end
        for (n = 0; n < 4 && n < exp_r.size(); n++)
            pop_check(exp_r[n], exp_f[n]);
        if (fifo_empty !== 1'b1 || fifo_overflow !== 1'b1)
            report_mismatch($sformatf("after drain empty %b overflow %b",
                fifo_empty, fifo_overflow));
    endtask

    task automatic empty_pop();
        alu_pkg::alu_word_t  r0;
        alu_pkg::alu_flags_t f0;
        r0 = head_result;
        f0 = head_flags;
        result_pop = 1'b1;
        tick();
        result_pop = 1'b0;
        tick();
        if (fifo_empty !== 1'b1 || head_result !== r0 || head_flags !== f0)
            report_mismatch($sformatf("pop on empty FIFO changed empty %b head %h flags %b",
                fifo_empty, head_result, head_flags));
    endtask

    initial begin
        wait (timed_out);
        $display("Summary: %0d checked, %0d errors, %0d skipped", n_checked, n_errors, n_skipped);
        $display("Errors found");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        operand_a  = '0;
        operand_b  = '0;
        alu_op     = '0;
        alu_enable = 1'b0;
        result_pop = 1'b0;
        rng        = 32'h4470;
        m_lfsr     = `ALU_LFSR_SEED;
        m_sel      = '0;
        m_armed    = 1'b0;
        repeat (5) tick();
        rst = 1'b0;
        if (fifo_empty !== 1'b1 || fifo_overflow !== 1'b0 || i_dut.result_strobe !== 1'b0
                || i_dut.force_clear !== 1'b0)
            report_mismatch("outputs not at their reset values");
        tick();
        directed_ops();
        random_ops();
        run_trigger();
        fill_fifo();
        empty_pop();
        $display("Summary: %0d checked, %0d errors, %0d skipped", n_checked, n_errors, n_skipped);
        if (n_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- hdl/alu_core.sv
// Multi-cycle 16-bit ALU with flag generation,
// tap byte LFSR and external forced clear
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_core (
    input  logic                clk,
    input  logic                rst,
    input  alu_pkg::alu_word_t  operand_a,
    input  alu_pkg::alu_word_t  operand_b,
    input  alu_pkg::alu_op_t    alu_op,
    input  logic                alu_enable,
    input  logic                force_clear,
    output alu_pkg::alu_word_t  result,
    output alu_pkg::alu_flags_t flags,
    output logic                result_strobe,
    output trig_pkg::tap_byte_t tap_byte,
    output logic                tap_valid
);

    localparam int W = `ALU_DATA_WIDTH;

    alu_pkg::alu_state_t state;
    logic                done;       // Result already produced for this enable

    // Execute stage outputs
    alu_pkg::alu_sum_t  add_sub;
    alu_pkg::alu_wide_t product;
    alu_pkg::alu_word_t calc_word;

    // Registered at the end of EXECUTE
    alu_pkg::alu_op_t   exec_op;
    logic               exec_carry;   // Top bit of the sum or difference
    alu_pkg::alu_word_t exec_word;
    logic               exec_mul_hi;  // High product half nonzero
    logic [1:0]         exec_a_top;   // operand_a bits W-1 and W-2
    logic               exec_b_msb;

    // Flags computed in RESULT
    logic flag_zero;
    logic flag_carry;
    logic flag_ovf;
    logic flag_neg;

    trig_pkg::lfsr_t    lfsr;
    trig_pkg::tap_sel_t tap_sel;

    // Tap stream, advanced only on enabled cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr    <= `ALU_LFSR_SEED;
            tap_sel <= '0;
        end else if (alu_enable) begin
            lfsr    <= {lfsr[18:0], lfsr[19] ^ lfsr[16] ^ lfsr[13] ^ lfsr[1]};
            tap_sel <= tap_sel + 2'd1;
        end
    end

    always_comb begin
        case (tap_sel)
            2'd0:    tap_byte = lfsr[7:0];
            2'd1:    tap_byte = lfsr[15:8];
            2'd2:    tap_byte = lfsr[19:12] ^ operand_a[7:0];
            default: tap_byte = lfsr[7:0] ^ operand_b[7:0];
        endcase
    end

    assign tap_valid = alu_enable;

    // Arithmetic on live operands
    assign add_sub = (alu_op == `OP_SUB) ? ({1'b0, operand_a} - {1'b0, operand_b})
                                         : ({1'b0, operand_a} + {1'b0, operand_b});
    assign product = operand_a * operand_b;

    always_comb begin
        case (alu_op)
            `OP_ADD, `OP_SUB: calc_word = add_sub[W-1:0];
            `OP_AND: calc_word = operand_a & operand_b;
            `OP_OR:  calc_word = operand_a | operand_b;
            `OP_XOR: calc_word = operand_a ^ operand_b;
            `OP_NOT: calc_word = ~operand_a;
            `OP_SHL: calc_word = {operand_a[W-2:0], 1'b0};
            `OP_SHR: calc_word = {1'b0, operand_a[W-1:1]};
            `OP_SLT: calc_word = ($signed(operand_a) < $signed(operand_b)) ? W'(1) : '0;
            `OP_EQ:  calc_word = (operand_a == operand_b) ? W'(1) : '0;
            `OP_MUL: calc_word = product[W-1:0];
            `OP_DIV: begin
                if (operand_b != '0)
                    calc_word = operand_a / operand_b;
                else
                    calc_word = '1;  // Divide by zero
            end
            default: calc_word = '0;
        endcase
    end

    // Flags from the registered execute stage
    assign flag_zero = (exec_word == '0);
    assign flag_neg  = exec_word[W-1];

    always_comb begin
        case (exec_op)
            `OP_ADD: begin
                flag_carry = exec_carry;
                flag_ovf   = (exec_a_top[1] == exec_b_msb) && (exec_word[W-1] != exec_a_top[1]);
            end
            `OP_SUB: begin
                flag_carry = exec_carry;  // Borrow
                flag_ovf   = (exec_a_top[1] != exec_b_msb) && (exec_word[W-1] != exec_a_top[1]);
            end
            `OP_SHL: begin
                flag_carry = exec_a_top[1];
                flag_ovf   = exec_a_top[1] ^ exec_a_top[0];
            end
            `OP_MUL: begin
                flag_carry = exec_mul_hi;
                flag_ovf   = exec_mul_hi;
            end
            default: begin
                flag_carry = 1'b0;
                flag_ovf   = 1'b0;
            end
        endcase
    end

    // Control FSM, one result per enable level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= alu_pkg::IDLE;
            done          <= 1'b0;
            result_strobe <= 1'b0;
        end else begin
            result_strobe <= 1'b0;
            if (force_clear) begin
                state <= alu_pkg::IDLE;
                done  <= 1'b0;
            end else begin
                case (state)
                    alu_pkg::IDLE: begin
                        if (!alu_enable)
                            done <= 1'b0;
                        else if (!done)
                            state <= alu_pkg::EXECUTE;
                    end
                    alu_pkg::EXECUTE: state <= alu_pkg::RESULT;
                    alu_pkg::RESULT: begin
                        state         <= alu_pkg::IDLE;
                        done          <= 1'b1;
                        result_strobe <= 1'b1;
                    end
                    default: state <= alu_pkg::IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == alu_pkg::EXECUTE) begin
            exec_op     <= alu_op;
            exec_carry  <= add_sub[W];
            exec_word   <= calc_word;
            exec_mul_hi <= (product[2*W-1:W] != '0);
            exec_a_top  <= operand_a[W-1:W-2];
            exec_b_msb  <= operand_b[W-1];
        end
        if (state == alu_pkg::RESULT) begin
            result <= exec_word;
            flags  <= {flag_zero, flag_carry, flag_ovf, flag_neg};
        end
    end

endmodule

//--- hdl/alu_pkg.sv
// ALU datapath types: operand word, wide intermediates,
// opcode, flag vector and control FSM states
`include "alu_consts.svh"

package alu_pkg;

    // Operand and result word
    typedef logic [`ALU_DATA_WIDTH-1:0] alu_word_t;

    // Sum or difference with carry out on top
    typedef logic [`ALU_DATA_WIDTH:0] alu_sum_t;

    // Full product before truncation
    typedef logic [2*`ALU_DATA_WIDTH-1:0] alu_wide_t;

    typedef logic [3:0] alu_op_t;

    // Bit 3 zero, bit 2 carry, bit 1 overflow, bit 0 negative
    typedef logic [3:0] alu_flags_t;

    // Control FSM
    typedef enum logic [1:0] {
        IDLE,
        EXECUTE,
        RESULT
    } alu_state_t;

endpackage

//--- hdl/alu_subsystem.sv
// ALU subsystem top: core, tap trigger monitor and result FIFO
`timescale 1ns/1ps

module alu_subsystem (
    input  logic                clk,
    input  logic                rst,
    input  alu_pkg::alu_word_t  operand_a,
    input  alu_pkg::alu_word_t  operand_b,
    input  alu_pkg::alu_op_t    alu_op,
    input  logic                alu_enable,
    input  logic                result_pop,
    output alu_pkg::alu_word_t  head_result,
    output alu_pkg::alu_flags_t head_flags,
    output logic                fifo_empty,
    output logic                fifo_full,
    output logic                fifo_overflow
);

    trig_pkg::tap_byte_t tap_byte;
    logic                tap_valid;
    logic                force_clear;
    alu_pkg::alu_word_t  core_result;
    alu_pkg::alu_flags_t core_flags;
    logic                result_strobe;

    alu_core i_core (
        .clk           (clk),
        .rst           (rst),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .alu_op        (alu_op),
        .alu_enable    (alu_enable),
        .force_clear   (force_clear),
        .result        (core_result),
        .flags         (core_flags),
        .result_strobe (result_strobe),
        .tap_byte      (tap_byte),
        .tap_valid     (tap_valid)
    );

    // Watches the tap stream for the clear pattern
    reset_trigger i_trigger (
        .clk         (clk),
        .rst         (rst),
        .tap_byte    (tap_byte),
        .tap_valid   (tap_valid),
        .force_clear (force_clear)
    );

    result_fifo i_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (result_strobe),
        .push_result (core_result),
        .push_flags  (core_flags),
        .pop         (result_pop),
        .head_result (head_result),
        .head_flags  (head_flags),
        .empty       (fifo_empty),
        .full        (fifo_full),
        .overflow    (fifo_overflow)
    );

endmodule

//--- hdl/reset_trigger.sv
// Tap byte monitor, pulses force_clear on the trigger byte pair
`timescale 1ns/1ps
`include "alu_consts.svh"

module reset_trigger (
    input  logic                clk,
    input  logic                rst,
    input  trig_pkg::tap_byte_t tap_byte,
    input  logic                tap_valid,
    output logic                force_clear
);

    trig_pkg::trig_state_t state;

    logic hit_first;
    logic hit_second;

    assign hit_first  = (tap_byte == `TRIG_BYTE0);
    assign hit_second = (tap_byte == `TRIG_BYTE1);

    // Only valid bytes move the monitor
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= trig_pkg::WAIT_FIRST;
            force_clear <= 1'b0;
        end else begin
            force_clear <= 1'b0;
            if (tap_valid) begin
                case (state)
                    trig_pkg::WAIT_FIRST: begin
                        if (hit_first)
                            state <= trig_pkg::WAIT_SECOND;
                    end
                    trig_pkg::WAIT_SECOND: begin
                        if (hit_second) begin
                            force_clear <= 1'b1;
                            state       <= trig_pkg::WAIT_FIRST;
                        end else if (!hit_first) begin
                            state <= trig_pkg::WAIT_FIRST;  // Pattern broken
                        end
                        // Another first byte keeps it armed
                    end
                    default: state <= trig_pkg::WAIT_FIRST;
                endcase
            end
        end
    end

endmodule

//--- hdl/result_fifo.sv
// Result and flag FIFO with registered head and sticky overflow
`timescale 1ns/1ps
`include "alu_consts.svh"

module result_fifo (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  alu_pkg::alu_word_t  push_result,
    input  alu_pkg::alu_flags_t push_flags,
    input  logic                pop,
    output alu_pkg::alu_word_t  head_result,
    output alu_pkg::alu_flags_t head_flags,
    output logic                empty,
    output logic                full,
    output logic                overflow
);

    localparam int DEPTH = `ALU_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    alu_pkg::alu_word_t  mem_result [DEPTH];
    alu_pkg::alu_flags_t mem_flags  [DEPTH];

    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_next;
    logic [CW-1:0] count;

    logic do_pop;
    logic do_push;

    assign empty   = (count == '0);
    assign full    = (count == CW'(DEPTH));
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);  // Pop frees a slot
    assign rd_next = (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_result[wr_ptr] <= push_result;
            mem_flags[wr_ptr]  <= push_flags;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr      <= '0;
            wr_ptr      <= '0;
            count       <= '0;
            overflow    <= 1'b0;
            head_result <= '0;
            head_flags  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_next;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
            if (push && !do_push)
                overflow <= 1'b1;  // Dropped word, held until reset
            // Head follows the oldest entry
            if (do_push && (empty || (do_pop && count == CW'(1)))) begin
                head_result <= push_result;
                head_flags  <= push_flags;
            end else if (do_pop && count > CW'(1)) begin
                head_result <= mem_result[rd_next];
                head_flags  <= mem_flags[rd_next];
            end
        end
    end

endmodule

//--- hdl/trig_pkg.sv
// Tap stream and trigger monitor types
// LFSR state, tap select, tap byte, monitor states

package trig_pkg;

    // Tap generator state
    typedef logic [19:0] lfsr_t;

    // Rotating source select for the tap byte
    typedef logic [1:0] tap_sel_t;

    typedef logic [7:0] tap_byte_t;

    // Pattern monitor
    typedef enum logic {
        WAIT_FIRST,
        WAIT_SECOND
    } trig_state_t;

endpackage

//--- include/alu_consts.svh
// ALU subsystem constants: widths, FIFO depth, LFSR seed,
// trigger pattern and opcode encodings
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

`define ALU_DATA_WIDTH 16
`define ALU_FIFO_DEPTH 4
`define ALU_LFSR_SEED  20'hABCDE

// Byte pair watched on the tap stream
`define TRIG_BYTE0 8'hA5
`define TRIG_BYTE1 8'h5A

`define OP_ADD 4'd0
`define OP_SUB 4'd1
`define OP_AND 4'd2
`define OP_OR  4'd3
`define OP_XOR 4'd4
`define OP_NOT 4'd5
`define OP_SHL 4'd6
`define OP_SHR 4'd7
`define OP_SLT 4'd8  // Signed compare
`define OP_EQ  4'd9
`define OP_MUL 4'd10 // Low half only
`define OP_DIV 4'd11 // Unsigned

`endif

//--- tb.f
+incdir+include
hdl/alu_pkg.sv
hdl/trig_pkg.sv
hdl/alu_core.sv
hdl/reset_trigger.sv
hdl/result_fifo.sv
hdl/alu_subsystem.sv
bench/alu_subsystem_sva.sv
bench/tb_alu_subsystem.sv
